//--- hw/host_ctrl_pkg.sv
/*
  host control receive path, shared definitions
  stream word widths, the two fixed command headers matched on the
  MAC receive stream, and the slow-down hold length and states
*/

`default_nettype none

package host_ctrl_pkg;

  ////////////////////////////////////////
  // stream widths
  ////////////////////////////////////////

  typedef logic [31:0]  word_t;        // one received stream word
  typedef logic [3:0]   keep_t;        // byte enables of a word
  typedef logic [159:0] cmd_string_t;  // word 0 in bits [31:0], first on the wire
  typedef logic [2:0]   word_idx_t;    // frame position, saturates at cmd_words
  typedef logic [47:0]  mac_t;
  typedef logic [15:0]  ether_type_t;
  typedef logic [47:0]  cmd_tag_t;     // 6 ascii chars, byte swapped per word

  localparam int cmd_words = 5;

  ////////////////////////////////////////
  // command headers
  ////////////////////////////////////////

  localparam mac_t        host_dst_mac  = 48'h4502_1111_6843;
  localparam mac_t        host_src_mac  = 48'h8f54_0000_1654;
  localparam ether_type_t host_cmd_type = 16'h005c;

  localparam cmd_tag_t trigger_tag = 48'h6e69_6769_7274;  // "trigin"
  localparam cmd_tag_t slow_tag    = 48'h656d_776f_6c73;  // "slowme"

  // tag upper 32 | tag lower 16 | type | src mac | dst mac
  localparam cmd_string_t trigger_string = {
    trigger_tag[47:16], trigger_tag[15:0], host_cmd_type, host_src_mac, host_dst_mac
  };
  localparam cmd_string_t slow_string = {
    slow_tag[47:16], slow_tag[15:0], host_cmd_type, host_src_mac, host_dst_mac
  };

  ////////////////////////////////////////
  // slow-down hold
  ////////////////////////////////////////

  typedef logic [16:0] hold_count_t;

  localparam hold_count_t slow_hold_cycles = 17'd20000;  // count value ending the hold

  typedef enum logic {
    slow_idle,
    slow_hold
  } slow_state_t;

endpackage

`default_nettype wire

//--- hw/header_matcher.sv
/*
  header matcher
  compares the first cmd_words words of each received frame with a
  fixed command header and pulses match for one cycle after the last
  word of a frame whose header agrees in full
*/

`timescale 1ns/1ps
`default_nettype none

module header_matcher #(
  parameter host_ctrl_pkg::cmd_string_t pattern = host_ctrl_pkg::trigger_string
) (
  input  wire                   CPUCLK,
  input  wire                   bus_struct_reset,
  input  host_ctrl_pkg::word_t  rx_data,
  input  host_ctrl_pkg::keep_t  rx_keep,
  input  wire                   rx_valid,
  input  wire                   rx_last,
  output logic                  match
);

  import host_ctrl_pkg::*;

  localparam word_idx_t last_hdr_idx = word_idx_t'(cmd_words - 1);
  localparam word_idx_t idx_sat      = word_idx_t'(cmd_words);
  localparam int        word_bits    = $bits(word_t);

  word_idx_t word_idx;    // position of the next accepted word
  logic      mismatch;    // frame already failed
  word_t     exp_word;
  logic      in_header;
  logic      word_ok;
  logic      too_short;
  logic      frame_bad;

  ////////////////////////////////////////
  // compare against the header
  ////////////////////////////////////////

  // header word for the current position
  always_comb begin
    exp_word = '0;
    for (int i = 0; i < cmd_words; i++) begin
      if (word_idx == word_idx_t'(i)) begin
        exp_word = pattern[i*word_bits +: word_bits];
      end
    end
  end

  assign in_header = (word_idx < idx_sat);
  assign word_ok   = (rx_data == exp_word) && (&rx_keep);  // all bytes must be enabled

  // last word arriving before the header is complete
  assign too_short = rx_last && (word_idx < last_hdr_idx);

  // words past the header do not count
  assign frame_bad = mismatch || (in_header && !word_ok) || too_short;

  ////////////////////////////////////////
  // frame tracking
  ////////////////////////////////////////

  always_ff @(posedge CPUCLK) begin
    if (bus_struct_reset) begin
      word_idx <= '0;
      mismatch <= 1'b0;
    end else if (rx_valid) begin
      if (rx_last) begin
        // next frame starts clean
        word_idx <= '0;
        mismatch <= 1'b0;
      end else begin
        if (word_idx != idx_sat) begin
          word_idx <= word_idx + 1'b1;
        end
        mismatch <= frame_bad;
      end
    end
  end

  // registered one-cycle pulse
  always_ff @(posedge CPUCLK) begin
    if (bus_struct_reset) begin
      match <= 1'b0;
    end else begin
      match <= rx_valid && rx_last && !frame_bad;
    end
  end

endmodule

`default_nettype wire

//--- hw/slowdown_timer.sv
/*
  slow-down hold timer
  a host slow-down request starts a fixed hold during which the core
  is stalled, requests seen during a hold are dropped
*/

`timescale 1ns/1ps
`default_nettype none

module slowdown_timer (
  input  wire  CPUCLK,
  input  wire  bus_struct_reset,
  input  wire  slow_request,
  output logic host_stall
);

  import host_ctrl_pkg::*;

  slow_state_t state;
  slow_state_t next_state;
  hold_count_t count;
  logic        count_clear;
  logic        count_en;
  logic        hold_done;

  ////////////////////////////////////////
  // state machine
  ////////////////////////////////////////

  always_ff @(posedge CPUCLK) begin
    if (bus_struct_reset) state <= slow_idle;
    else                  state <= next_state;
  end

  always_comb begin
    case (state)
      slow_idle: next_state = slow_request ? slow_hold : slow_idle;
      slow_hold: next_state = hold_done ? slow_idle : slow_hold;  // new requests ignored here
      default:   next_state = slow_idle;
    endcase
  end

  ////////////////////////////////////////
  // hold counter
  ////////////////////////////////////////

  assign count_clear = (state == slow_idle);
  assign count_en    = (state == slow_hold);
  assign hold_done   = (count == slow_hold_cycles);

  // sits at zero while idle, so a hold always starts from 0
  always_ff @(posedge CPUCLK) begin
    if (bus_struct_reset || count_clear) begin
      count <= '0;
    end else if (count_en) begin
      count <= count + 1'b1;
    end
  end

  assign host_stall = (state == slow_hold);  // slow_hold_cycles + 1 cycles

endmodule

`default_nettype wire

//--- hw/host_ctrl_top.sv
/*
  host control receive path
  watches the MAC receive stream for the debug trigger and the
  slow-down command, drives the logic-analyzer trigger and merges
  the host stall with the packetizer stall
*/

`timescale 1ns/1ps
`default_nettype none

module host_ctrl_top (
  input  wire                   CPUCLK,
  input  wire                   bus_struct_reset,
  input  host_ctrl_pkg::word_t  rx_data,
  input  host_ctrl_pkg::keep_t  rx_keep,
  input  wire                   rx_valid,
  input  wire                   rx_last,
  input  wire                   rvvi_stall,
  output logic                  ila_trigger,
  output logic                  external_stall
);

  import host_ctrl_pkg::*;

  logic slow_request;  // one-cycle pulse per slow-down frame
  logic host_stall;

  ////////////////////////////////////////
  // command decode
  ////////////////////////////////////////

  header_matcher #(
    .pattern (trigger_string)
  ) trigger_match (
    .CPUCLK           (CPUCLK),
    .bus_struct_reset (bus_struct_reset),
    .rx_data          (rx_data),
    .rx_keep          (rx_keep),
    .rx_valid         (rx_valid),
    .rx_last          (rx_last),
    .match            (ila_trigger)   // 1 cycle after last word
  );

  header_matcher #(
    .pattern (slow_string)
  ) slow_match (
    .CPUCLK           (CPUCLK),
    .bus_struct_reset (bus_struct_reset),
    .rx_data          (rx_data),
    .rx_keep          (rx_keep),
    .rx_valid         (rx_valid),
    .rx_last          (rx_last),
    .match            (slow_request)
  );

  ////////////////////////////////////////
  // slow-down hold and stall merge
  ////////////////////////////////////////

  slowdown_timer slowdown (
    .CPUCLK           (CPUCLK),
    .bus_struct_reset (bus_struct_reset),
    .slow_request     (slow_request),
    .host_stall       (host_stall)
  );

  // packetizer stall passes straight through
  assign external_stall = rvvi_stall | host_stall;

endmodule

`default_nettype wire

//--- verification/host_ctrl_model.svh
/*
  reference model for the host control receive path
  judges each frame against both command headers and keeps a
  cycle-exact shadow of the slow-down hold, stepped once per cycle
*/

`ifndef HOST_CTRL_MODEL_SVH
`define HOST_CTRL_MODEL_SVH

// index 0 is the trigger header, index 1 the slow-down header
int          m_pos [2];
bit          m_bad [2];
bit          exp_trigger = 1'b0;  // expected ila_trigger after the coming edge
bit          exp_request = 1'b0;  // expected slow-down match pulse
bit          m_hold = 1'b0;
hold_count_t m_count = '0;
int          holds_started = 0;
int          triggers_seen = 0;

function automatic word_t header_word(input int which, input int idx);
  cmd_string_t hdr;
  hdr = (which == 0) ? trigger_string : slow_string;
  return hdr[idx*32 +: 32];
endfunction

task automatic model_reset();
  for (int k = 0; k < 2; k++) begin
    m_pos[k] = 0;
    m_bad[k] = 1'b0;
  end
  exp_trigger = 1'b0;
  exp_request = 1'b0;
  m_hold      = 1'b0;
  m_count     = '0;
endtask

// one accepted word, hit is set on the last word of a good frame
task automatic judge_word(input int which, input word_t data, input keep_t keep,
                          input bit last, output bit hit);
  hit = 1'b0;
  if (m_pos[which] < cmd_words && (data != header_word(which, m_pos[which]) || keep != 4'hf))
    m_bad[which] = 1'b1;
  if (last) begin
    hit = !m_bad[which] && (m_pos[which] >= cmd_words - 1);  // at least 5 words
    m_pos[which] = 0;
    m_bad[which] = 1'b0;
  end else begin
    m_pos[which]++;
  end
endtask

// hold shadow sees the request pulse that is visible at this edge
task automatic timer_step(input bit request);
  if (m_hold) begin
    if (m_count == slow_hold_cycles) m_hold = 1'b0;
    else m_count++;
  end else if (request) begin
    m_hold  = 1'b1;
    m_count = '0;
    holds_started++;
  end
endtask

task automatic model_cycle(input bit valid, input word_t data, input keep_t keep, input bit last);
  bit trig_hit;
  bit slow_hit;
  trig_hit = 1'b0;
  slow_hit = 1'b0;
  timer_step(exp_request);
  if (valid) begin
    judge_word(0, data, keep, last, trig_hit);
    judge_word(1, data, keep, last, slow_hit);
  end
  exp_trigger = trig_hit;
  exp_request = slow_hit;
endtask

`endif

//--- verification/host_ctrl_tb.sv
/*
  testbench for the host control receive path
  random frames with idle gaps and a toggling packetizer stall,
  checked every cycle against the reference model
*/

`timescale 1ns/1ps
`default_nettype none

module host_ctrl_tb;

  import host_ctrl_pkg::*;

  localparam int num_frames   = 400;
  localparam int hold_timeout = 30000;  // cycles, longer than one hold

  logic  CPUCLK           = 1'b0;
  logic  bus_struct_reset = 1'b1;
  word_t rx_data          = '0;
  keep_t rx_keep          = '0;
  logic  rx_valid         = 1'b0;
  logic  rx_last          = 1'b0;
  logic  rvvi_stall       = 1'b0;
  logic  ila_trigger;
  logic  external_stall;

  int n_checks    = 0;
  int n_errors    = 0;
  bit model_ready = 1'b0;
  bit timed_out   = 1'b0;
  bit quiet_stall = 1'b0;  // rvvi_stall held low, host stall edges visible

  `include "host_ctrl_model.svh"

  host_ctrl_top dut (
    .CPUCLK           (CPUCLK),
    .bus_struct_reset (bus_struct_reset),
    .rx_data          (rx_data),
    .rx_keep          (rx_keep),
    .rx_valid         (rx_valid),
    .rx_last          (rx_last),
    .rvvi_stall       (rvvi_stall),
    .ila_trigger      (ila_trigger),
    .external_stall   (external_stall)
  );

  always #5 CPUCLK = ~CPUCLK;  // 10 ns

  task automatic check_value(input logic [31:0] got, input logic [31:0] exp, input string what);
    n_checks++;
    if (got !== exp) begin
      n_errors++;
      $display("error at %0t: %s got %0h expected %0h", $time, what, got, exp);
    end
  endtask

  ////////////////////////////////////////
  // stimulus
  ////////////////////////////////////////

  task automatic drive_cycle(input bit valid, input word_t data, input keep_t keep, input bit last);
    @(posedge CPUCLK);
    rx_valid <= valid;
    rx_data  <= data;
    rx_keep  <= keep;
    rx_last  <= last;
    if (quiet_stall) rvvi_stall <= 1'b0;
    else if ($urandom % 8 == 0) rvvi_stall <= ~rvvi_stall;
  endtask

  // junk on data and last while invalid
  task automatic drive_idle(input int cycles);
    for (int c = 0; c < cycles; c++)
      drive_cycle(1'b0, word_t'($urandom), keep_t'($urandom), 1'($urandom));
  endtask

  task automatic send_header_frame(input int which, input int len, input bit gaps);
    for (int i = 0; i < len; i++) begin
      if (gaps && i % 2 == 1) drive_idle(1 + $urandom % 2);
      drive_cycle(1'b1, (i < cmd_words) ? header_word(which, i) : word_t'($urandom),
                  4'hf, i == len - 1);
    end
  endtask

  // kinds: trigger, slow-down, corrupted word, partial keep, short, random
  task automatic send_random_frame(input bit allow_slow);
    int    kind;
    int    which;
    int    len;
    int    bad_idx;
    word_t data;
    keep_t keep;
    kind    = $urandom % 6;
    if (!allow_slow && kind == 1) kind = 0;  // timer stays idle, false slow matches show
    which   = (kind < 2) ? kind : $urandom % 2;
    len     = (kind == 4) ? 1 + $urandom % 4 : (kind == 5) ? 1 + $urandom % 8 : 5 + $urandom % 4;
    bad_idx = $urandom % cmd_words;
    for (int i = 0; i < len; i++) begin
      data = (i < cmd_words && kind != 5) ? header_word(which, i) : word_t'($urandom);
      keep = (kind == 5) ? keep_t'($urandom) : 4'hf;
      if (kind == 2 && i == bad_idx) data = data ^ (word_t'(1) << ($urandom % 32));
      if (kind == 3 && i == bad_idx) keep = keep_t'($urandom % 15);  // never all four
      if (i > 0 && $urandom % 4 == 0) drive_idle(1 + $urandom % 3);
      drive_cycle(1'b1, data, keep, i == len - 1);
    end
  endtask

  task automatic wait_hold_end();
    int n;
    n = 0;
    drive_idle(3);  // a pending request turns into a hold first
    while (m_hold && n < hold_timeout) begin
      drive_idle(1);
      n++;
    end
    if (m_hold) begin
      $display("timeout: slow-down hold still active after %0d cycles", n);
      n_errors++;
      timed_out = 1'b1;
    end
  endtask

  ////////////////////////////////////////
  // per-cycle compare against the model
  ////////////////////////////////////////

  always @(negedge CPUCLK) begin
    if (model_ready) begin
      check_value(32'(ila_trigger), 32'(exp_trigger), "ila_trigger");
      check_value(32'(external_stall), 32'(rvvi_stall | m_hold), "external_stall");
      if (ila_trigger === 1'b1) triggers_seen++;
    end
    if (bus_struct_reset) begin
      model_reset();
      model_ready = 1'b1;
    end else begin
      model_cycle(rx_valid, rx_data, rx_keep, rx_last);
    end
  end

  initial begin
    int t0;
    void'($urandom(32'h87c9_beea));
    repeat (4) @(posedge CPUCLK);
    bus_struct_reset <= 1'b0;

    for (int f = 0; f < num_frames; f++) begin
      send_random_frame(f >= num_frames / 2);  // holds only in the second half
      drive_idle($urandom % 4);  // zero gives back-to-back frames
    end
    wait_hold_end();

    if (!timed_out) begin
      quiet_stall = 1'b1;
      // trailing words and gaps inside the frame
      t0 = triggers_seen;
      send_header_frame(0, 7, 1'b1);
      drive_idle(2);
      check_value(triggers_seen - t0, 1, "pulses for one trigger frame");
      t0 = triggers_seen;
      send_header_frame(0, 5, 1'b0);
      send_header_frame(1, 6, 1'b0);
      drive_idle(2);
      check_value(triggers_seen - t0, 1, "pulses for trigger then slow-down");
      wait_hold_end();
    end

    check_value(32'(triggers_seen > 0), 1, "trigger pulses seen");
    check_value(32'(holds_started >= 2), 1, "slow-down holds started");
    $display("checks %0d, errors %0d", n_checks, n_errors);
    if (n_errors == 0)
      $display("ALL CHECKS PASSED");
    else
      $display("CHECKS FAILED");
    $finish;
  end

endmodule

`default_nettype wire

//--- host_ctrl_top.f
+incdir+verification
hw/host_ctrl_pkg.sv
hw/header_matcher.sv
hw/slowdown_timer.sv
hw/host_ctrl_top.sv
verification/host_ctrl_tb.sv

//--- Makefile
TOOL       = verilator
TOP        = host_ctrl_tb
RTL_TOP    = host_ctrl_top
FILELIST   = host_ctrl_top.f
LINT_FLAGS = --lint-only --timing
SIM_FLAGS  = --binary --timing -j 0
BUILD_DIR  = obj_dir
LOG        = sim.log
PASS_MSG   = ALL CHECKS PASSED

.PHONY: all lint sim clean

all: sim

# lint the testbench with the whole design under it
lint:
	$(TOOL) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

# build, run, then decide pass or fail from the log
sim:
	$(TOOL) $(SIM_FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -qx "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
